// ==== hdl/wb_pkg.sv ====
// Wishbone bus widths and byte select constants for the trace writer and its memory slave
package wb_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------

  // Byte address width
  localparam int WB_AW = 32;

  // Data width, one trace word per transfer
  localparam int WB_DW = 32;

  // One select bit per byte lane
  localparam int WB_SEL_W = WB_DW / 8;

  // Word address to byte address shift
  localparam int WB_ADR_LSB = 2;

  // ----------------------------------------
  // Select constants
  // ----------------------------------------

  // Full word write, every byte lane enabled
  localparam logic [WB_SEL_W-1:0] WB_SEL_ALL = {WB_SEL_W{1'b1}};

endpackage

// ==== hdl/trace_pkg.sv ====
// Trace record formats shared by the capture stage, the FIFO, the writer and the testbench
package trace_pkg;

  // ----------------------------------------
  // Field widths
  // ----------------------------------------

  // Cycle stamp carried in an instruction header
  localparam int CYCLE_W = 23;
  // Saturating drop count carried in an overflow header
  localparam int DROP_W  = 24;

  // ----------------------------------------
  // Record kinds
  // ----------------------------------------

  // Nonzero codes, so a cleared memory word never decodes as a record
  typedef enum logic [1:0] {
    REC_INSTR = 2'd1,
    REC_OVF   = 2'd2
  } rec_kind_e;

  // ----------------------------------------
  // Header views
  // ----------------------------------------

  // Header of a retired instruction
  typedef struct packed {
    rec_kind_e            kind;
    logic                 has_wdata;  // Fourth word holds rd write data
    logic                 compressed; // 16-bit encoding
    logic [4:0]           rd;         // Destination register, 0 when no write
    logic [CYCLE_W-1:0]   cycle;      // Cycle stamp at the retire edge
  } instr_hdr_t;

  // Header of an overflow record
  typedef struct packed {
    rec_kind_e            kind;
    logic [5:0]           rsvd;
    logic [DROP_W-1:0]    drop_cnt;   // Retirements lost before this record
  } ovf_hdr_t;

  // One header word, decoded by whichever view the kind field selects
  // Kind sits in the top two bits of both views
  typedef union packed {
    instr_hdr_t instr;
    ovf_hdr_t   ovf;
  } trace_hdr_u;

  // ----------------------------------------
  // Full record
  // ----------------------------------------

  // Word order in memory: header, PC, instruction, write data
  // word_cnt holds the number of valid words minus one
  //   0 -> overflow record, header only
  //   2 -> instruction without write data
  //   3 -> instruction with write data
  typedef struct packed {
    logic [1:0]  word_cnt;
    trace_hdr_u  hdr;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] wdata;
  } trace_rec_t;

endpackage

// ==== hdl/trace_capture.sv ====
// Retire port sampler that stamps and packs trace records, and counts drops under back-pressure
module trace_capture (
  input  logic                clk_i,
  input  logic                rst_n,

  // Retire port of the core
  input  logic                retire_valid,
  input  logic [31:0]         retire_pc,
  input  logic [31:0]         retire_instr,
  input  logic                retire_compressed,

  // Register write-back, same cycle as retire_valid
  input  logic                rd_we,
  input  logic [4:0]          rd_addr,
  input  logic [31:0]         rd_wdata,

  // FIFO write side
  input  logic                full,
  output logic                push,
  output trace_pkg::trace_rec_t push_rec
);

  // ----------------------------------------
  // Counters
  // ----------------------------------------

  // Free-running stamp, wraps silently
  logic [trace_pkg::CYCLE_W-1:0] cycle_cnt;

  // Retirements lost since the last overflow record
  logic [trace_pkg::DROP_W-1:0]  drop_cnt;

  logic                          ovf_pending;
  logic                          push_ovf;
  logic                          push_instr;
  logic                          has_wdata;
  trace_pkg::trace_hdr_u         hdr;

  // Zero at the first edge after reset release
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  // ----------------------------------------
  // Push decision
  // ----------------------------------------

  assign ovf_pending = (drop_cnt != '0);

  // Overflow record goes first once there is room
  assign push_ovf    = ovf_pending && !full;

  // Instruction only when nothing is pending, keeps program order
  assign push_instr  = retire_valid && !full && !ovf_pending;

  assign push        = push_ovf || push_instr;

  // Writes to x0 carry no data
  assign has_wdata   = rd_we && (rd_addr != 5'd0);

  // Drop counter
  // A retirement in the cycle of the overflow push starts the next count
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      drop_cnt <= '0;
    end else if (push_ovf) begin
      drop_cnt <= trace_pkg::DROP_W'(retire_valid);
    end else if (retire_valid && full) begin
      // Saturate rather than wrap
      if (drop_cnt != '1) begin
        drop_cnt <= drop_cnt + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Record packing
  // ----------------------------------------

  // Header through the view matching the record kind
  always_comb begin
    hdr = '0;
    if (ovf_pending) begin
      hdr.ovf.kind     = trace_pkg::REC_OVF;
      hdr.ovf.drop_cnt = drop_cnt;
    end else begin
      hdr.instr.kind       = trace_pkg::REC_INSTR;
      hdr.instr.has_wdata  = has_wdata;
      hdr.instr.compressed = retire_compressed;
      hdr.instr.rd         = rd_we ? rd_addr : 5'd0;
      hdr.instr.cycle      = cycle_cnt;
    end
  end

  always_comb begin
    push_rec.hdr   = hdr;
    push_rec.pc    = retire_pc;
    push_rec.instr = retire_instr;
    push_rec.wdata = has_wdata ? rd_wdata : 32'd0;
    // Word count minus one
    if (ovf_pending) begin
      push_rec.word_cnt = 2'd0;
    end else if (has_wdata) begin
      push_rec.word_cnt = 2'd3;
    end else begin
      push_rec.word_cnt = 2'd2;
    end
  end

endmodule

// ==== hdl/trace_fifo.sv ====
// Record FIFO between the capture stage and the Wishbone writer with a parameter depth
module trace_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  logic                  push,
  input  trace_pkg::trace_rec_t push_rec,
  input  logic                  pop,
  output logic                  full,
  output logic                  empty,
  output trace_pkg::trace_rec_t head_rec
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // Record storage
  trace_pkg::trace_rec_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_nxt;
  logic             do_push;
  logic             do_pop;

  // Guard against overrun and underrun
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Pointer step that wraps at any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ----------------------------------------
  // Occupancy
  // ----------------------------------------

  // Push and pop together leave the count alone
  always_comb begin
    count_nxt = count;
    if (do_push && !do_pop) begin
      count_nxt = count + 1'b1;
    end else if (do_pop && !do_push) begin
      count_nxt = count - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count <= count_nxt;
      // Flags registered from the next count
      full  <= (count_nxt == CNT_W'(FIFO_DEPTH));
      empty <= (count_nxt == '0);
    end
  end

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_rec;
    end
  end

  // Oldest record shows the cycle after its push
  assign head_rec = mem[rd_ptr];

endmodule

// ==== hdl/trace_wb_writer.sv ====
// Wishbone classic master that drains trace records word by word into a circular memory window
module trace_wb_writer #(
  parameter logic [wb_pkg::WB_AW-1:0] TRACE_BASE  = 32'h0001_0000,
  parameter int                       TRACE_WORDS = 64
) (
  input  logic                         clk_i,
  input  logic                         rst_n,

  // FIFO read side
  input  logic                         empty,
  input  trace_pkg::trace_rec_t        head_rec,
  output logic                         pop,

  // Wishbone master
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic                         wb_we,
  output logic [wb_pkg::WB_AW-1:0]     wb_adr,
  output logic [wb_pkg::WB_DW-1:0]     wb_dat,
  output logic [wb_pkg::WB_SEL_W-1:0]  wb_sel,
  input  logic                         wb_ack
);

  // Window pointer wraps for free, TRACE_WORDS is a power of two
  localparam int PTR_W = $clog2(TRACE_WORDS);

  localparam logic ST_IDLE  = 1'b0;
  localparam logic ST_WRITE = 1'b1;

  logic             state;
  logic [1:0]       word_idx;   // Word of the head record on the bus
  logic [PTR_W-1:0] win_ptr;    // Next free word in the window
  logic             last_word;

  assign last_word = (word_idx == head_rec.word_cnt);

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      word_idx <= '0;
      win_ptr  <= '0;
      pop      <= 1'b0;
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      wb_we    <= 1'b0;
    end else begin
      pop <= 1'b0;
      case (state)
        ST_IDLE: begin
          // Skip the cycle where the pop of the last record lands
          if (!empty && !pop) begin
            state    <= ST_WRITE;
            word_idx <= '0;
            wb_cyc   <= 1'b1;
            wb_stb   <= 1'b1;
            wb_we    <= 1'b1;
          end
        end
        ST_WRITE: begin
          if (!wb_stb) begin
            // Gap cycle done, start the next word
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_we  <= 1'b1;
          end else if (wb_ack) begin
            wb_cyc  <= 1'b0;
            wb_stb  <= 1'b0;
            wb_we   <= 1'b0;
            win_ptr <= win_ptr + 1'b1;
            if (last_word) begin
              // Release the record one cycle after its last ack
              state <= ST_IDLE;
              pop   <= 1'b1;
            end else begin
              word_idx <= word_idx + 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Address and data
  // ----------------------------------------

  // Stable while stb is high, inputs only move on ack or pop
  assign wb_adr = TRACE_BASE + (wb_pkg::WB_AW'(win_ptr) << wb_pkg::WB_ADR_LSB);

  always_comb begin
    case (word_idx)
      2'd0:    wb_dat = head_rec.hdr;
      2'd1:    wb_dat = head_rec.pc;
      2'd2:    wb_dat = head_rec.instr;
      default: wb_dat = head_rec.wdata;
    endcase
  end

  // Whole words only
  assign wb_sel = wb_pkg::WB_SEL_ALL;

endmodule

// ==== hdl/trace_top.sv ====
// Instruction trace unit top level, retire port in and Wishbone classic master out
module trace_top #(
  parameter int                       FIFO_DEPTH  = 4,
  parameter logic [wb_pkg::WB_AW-1:0] TRACE_BASE  = 32'h0001_0000,
  parameter int                       TRACE_WORDS = 64
) (
  input  logic                         clk_i,
  input  logic                         rst_n,

  // Core retire and write-back
  input  logic                         retire_valid,
  input  logic [31:0]                  retire_pc,
  input  logic [31:0]                  retire_instr,
  input  logic                         retire_compressed,
  input  logic                         rd_we,
  input  logic [4:0]                   rd_addr,
  input  logic [31:0]                  rd_wdata,

  // Wishbone master to system memory
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic                         wb_we,
  output logic [wb_pkg::WB_AW-1:0]     wb_adr,
  output logic [wb_pkg::WB_DW-1:0]     wb_dat,
  output logic [wb_pkg::WB_SEL_W-1:0]  wb_sel,
  input  logic                         wb_ack
);

  // ----------------------------------------
  // Internal wires
  // ----------------------------------------

  logic                  push;
  logic                  full;
  logic                  empty;
  logic                  pop;
  trace_pkg::trace_rec_t push_rec;
  trace_pkg::trace_rec_t head_rec;

  // Producer, never stalls the core
  trace_capture i_capture (
    .clk_i, .rst_n,
    .retire_valid, .retire_pc, .retire_instr, .retire_compressed,
    .rd_we, .rd_addr, .rd_wdata,
    .full, .push, .push_rec
  );

  // Record buffer
  trace_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
    .clk_i, .rst_n,
    .push, .push_rec, .pop,
    .full, .empty, .head_rec
  );

  // Consumer on the bus
  trace_wb_writer #(.TRACE_BASE(TRACE_BASE), .TRACE_WORDS(TRACE_WORDS)) i_writer (
    .clk_i, .rst_n,
    .empty, .head_rec, .pop,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat, .wb_sel, .wb_ack
  );

endmodule

// ==== dv/trace_asserts.sv ====
// Wishbone protocol and FIFO flag assertions, bound into the trace unit top level
module trace_asserts (
  input logic                     clk_i,
  input logic                     rst_n,
  input logic                     wb_cyc,
  input logic                     wb_stb,
  input logic                     wb_ack,
  input logic [wb_pkg::WB_AW-1:0] wb_adr,
  input logic [wb_pkg::WB_DW-1:0] wb_dat,
  input logic                     full,
  input logic                     empty
);
  timeunit 1ns;
  timeprecision 1ps;

  // ----------------------------------------
  // Wishbone classic master
  // ----------------------------------------

  // Request held with fixed address and data until ack
  property p_stb_hold;
    @(posedge clk_i) disable iff (!rst_n)
      (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_dat));
  endproperty
  a_stb_hold: assert property (p_stb_hold)
    else $error("wb_stb dropped or wb_adr/wb_dat changed before wb_ack");

  // Strobe only inside a cycle
  a_stb_cyc: assert property (@(posedge clk_i) disable iff (!rst_n) wb_stb |-> wb_cyc)
    else $error("wb_stb high without wb_cyc");

  // ----------------------------------------
  // FIFO flags
  // ----------------------------------------

  a_flags: assert property (@(posedge clk_i) disable iff (!rst_n) !(full && empty))
    else $error("FIFO full and empty high together");

endmodule

bind trace_top trace_asserts i_asserts (
  .clk_i, .rst_n, .wb_cyc, .wb_stb, .wb_ack, .wb_adr, .wb_dat, .full, .empty
);

// ==== dv/trace_tb.sv ====
// Top-level testbench for the trace unit with random retirements, a Wishbone memory slave and a model
module trace_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          FIFO_DEPTH  = 4;
  localparam logic [31:0] TRACE_BASE  = 32'h0001_0000;
  localparam int          TRACE_WORDS = 64;

  // Sparse with fast ack, dense with slow ack, then mixed
  localparam int PH1_CYCLES  = 400;
  localparam int PH2_CYCLES  = 600;
  localparam int PH3_CYCLES  = 300;
  localparam int STIM_CYCLES = PH1_CYCLES + PH2_CYCLES + PH3_CYCLES;
  localparam int CYCLE_LIMIT = 10 * STIM_CYCLES;

  // Expected content of one instruction record
  typedef struct packed {
    logic [31:0]                   pc;
    logic [31:0]                   instr;
    logic [31:0]                   wdata;
    logic [trace_pkg::CYCLE_W-1:0] cycle;
    logic [4:0]                    rd;
    logic                          compressed;
    logic                          has_wdata;
  } exp_rec_t;

  logic clk_i;
  logic rst_n;
  logic retire_valid;
  logic [31:0] retire_pc;
  logic [31:0] retire_instr;
  logic retire_compressed;
  logic rd_we;
  logic [4:0] rd_addr;
  logic [31:0] rd_wdata;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [wb_pkg::WB_AW-1:0] wb_adr;
  logic [wb_pkg::WB_DW-1:0] wb_dat;
  logic [wb_pkg::WB_SEL_W-1:0] wb_sel;
  logic wb_ack = 1'b0;

  // Model and slave state
  exp_rec_t                      exp_q[$];
  logic [trace_pkg::CYCLE_W-1:0] model_cycle = '0;
  logic [31:0]                   mem [TRACE_WORDS];
  logic [31:0]                   tail [3];
  int unsigned tail_left = 0;
  int unsigned tail_idx = 0;
  int unsigned total_retired = 0;
  int unsigned instr_seen = 0;
  int unsigned dropped_total = 0;
  int unsigned ovf_seen = 0;
  int unsigned words_written = 0;
  int unsigned cycle_cnt = 0;
  int unsigned max_delay = 0;
  int unsigned ack_wait = 0;

  trace_top #(
    .FIFO_DEPTH(FIFO_DEPTH), .TRACE_BASE(TRACE_BASE), .TRACE_WORDS(TRACE_WORDS)
  ) i_dut (
    .clk_i, .rst_n,
    .retire_valid, .retire_pc, .retire_instr, .retire_compressed,
    .rd_we, .rd_addr, .rd_wdata,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat, .wb_sel, .wb_ack
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // ----------------------------------------
  // Reporting
  // ----------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run("Mismatch on the trace bus");
    end
  endtask

  function automatic string word_name(input int unsigned idx);
    case (idx)
      0:       return "wb_dat pc";
      1:       return "wb_dat instr";
      default: return "wb_dat wdata";
    endcase
  endfunction

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Record as the retire port shows it this cycle
  function automatic exp_rec_t make_expected();
    exp_rec_t r;
    r.pc         = retire_pc;
    r.instr      = retire_instr;
    r.wdata      = rd_wdata;
    r.cycle      = model_cycle;
    r.compressed = retire_compressed;
    // x0 writes carry no data word
    r.has_wdata  = rd_we && (rd_addr != 5'd0);
    r.rd         = rd_we ? rd_addr : 5'd0;
    return r;
  endfunction

  // Check one accepted bus word against the model
  task automatic take_write();
    trace_pkg::trace_hdr_u hdr;
    exp_rec_t              e;
    int unsigned           slot;
    slot = words_written % TRACE_WORDS;
    check_value("wb_sel", 32'(wb_sel), 32'(wb_pkg::WB_SEL_ALL));
    check_value("wb_we", 32'(wb_we), 32'd1);
    check_value("wb_adr", wb_adr, TRACE_BASE + 32'(slot * 4));
    if (i_dut.empty) begin
      abort_run("Bus write while the FIFO was empty");
    end
    mem[slot] = wb_dat;
    words_written++;
    if (tail_left != 0) begin
      check_value(word_name(tail_idx), wb_dat, tail[tail_idx]);
      tail_idx++;
      tail_left--;
    end else begin
      hdr = wb_dat;
      if (hdr.instr.kind == trace_pkg::REC_INSTR) begin
        if (exp_q.size() == 0) begin
          abort_run("Instruction record without a pending retirement");
        end
        e = exp_q.pop_front();
        instr_seen++;
        check_value("hdr.compressed", 32'(hdr.instr.compressed), 32'(e.compressed));
        check_value("hdr.has_wdata", 32'(hdr.instr.has_wdata), 32'(e.has_wdata));
        check_value("hdr.rd", 32'(hdr.instr.rd), 32'(e.rd));
        check_value("hdr.cycle", 32'(hdr.instr.cycle), 32'(e.cycle));
        tail[0]   = e.pc;
        tail[1]   = e.instr;
        tail[2]   = e.wdata;
        tail_idx  = 0;
        tail_left = e.has_wdata ? 3 : 2;
      end else if (hdr.ovf.kind == trace_pkg::REC_OVF) begin
        check_value("hdr.rsvd", 32'(hdr.ovf.rsvd), 32'd0);
        if (hdr.ovf.drop_cnt == '0 || hdr.ovf.drop_cnt > exp_q.size()) begin
          abort_run("Overflow record with a drop count out of range");
        end
        // Skipped retirements stand behind this record
        repeat (int'(hdr.ovf.drop_cnt)) e = exp_q.pop_front();
        dropped_total += hdr.ovf.drop_cnt;
        ovf_seen++;
      end else begin
        abort_run("Header word with an unknown record kind");
      end
    end
  endtask

  // Retirements and bus writes sampled at the falling edge
  always @(negedge clk_i) begin
    if (rst_n) begin
      if (retire_valid) begin
        exp_q.push_back(make_expected());
        total_retired++;
      end
      model_cycle++;
      if (wb_stb && wb_ack) begin
        take_write();
      end
    end
  end

  // Memory slave acks for one cycle after a random wait
  always @(posedge clk_i) begin
    #1;
    if (!rst_n) begin
      wb_ack   = 1'b0;
      ack_wait = 0;
    end else if (wb_ack) begin
      wb_ack   = 1'b0;
      ack_wait = $urandom_range(max_delay);
    end else if (wb_stb) begin
      if (ack_wait == 0) begin
        wb_ack = 1'b1;
      end else begin
        ack_wait--;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      abort_run("Run did not finish within the cycle limit");
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  task automatic drive_retire(input logic valid);
    retire_valid      = valid;
    retire_compressed = ($urandom_range(3) == 0);
    retire_pc         = $urandom() & (retire_compressed ? 32'hffff_fffe : 32'hffff_fffc);
    retire_instr      = retire_compressed ? {16'h0, 16'($urandom())} : 32'($urandom());
    rd_we             = 1'($urandom_range(1));
    // x0 now and then
    rd_addr           = ($urandom_range(7) == 0) ? 5'd0 : 5'($urandom());
    rd_wdata          = $urandom();
  endtask

  task automatic run_phase(input int cycles, input int unsigned pct, input int unsigned delay);
    max_delay = delay;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk_i);
      #1;
      drive_retire($urandom_range(99) < pct);
    end
    @(posedge clk_i);
    #1;
    retire_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (!(i_dut.empty && !i_dut.push && !wb_cyc)) begin
      @(posedge clk_i);
      #1;
    end
    // Quiet bus once all is drained
    repeat (16) begin
      @(posedge clk_i);
      #1;
      if (wb_cyc) begin
        abort_run("Bus write while stimulus and FIFO were idle");
      end
    end
  endtask

  initial begin
    void'($urandom(6));
    rst_n             = 1'b0;
    retire_valid      = 1'b0;
    retire_pc         = '0;
    retire_instr      = '0;
    retire_compressed = 1'b0;
    rd_we             = 1'b0;
    rd_addr           = '0;
    rd_wdata          = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n = 1'b1;
    run_phase(PH1_CYCLES, 20, 0);
    run_phase(PH2_CYCLES, 90, 10);
    run_phase(PH3_CYCLES, 40, 2);
    wait_drain();
    check_value("instr_seen+dropped", 32'(instr_seen + dropped_total), 32'(total_retired));
    if (exp_q.size() != 0 || tail_left != 0) begin
      abort_run("Run ended with trace words still expected");
    end else if (words_written <= TRACE_WORDS) begin
      abort_run("Too few words written to wrap the trace window");
    end else if (ovf_seen == 0) begin
      abort_run("No overflow record seen under back-pressure");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
hdl/wb_pkg.sv
hdl/trace_pkg.sv
hdl/trace_capture.sv
hdl/trace_fifo.sv
hdl/trace_wb_writer.sv
hdl/trace_top.sv
dv/trace_asserts.sv
dv/trace_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the trace unit testbench with Verilator and run it
# Exit status is nonzero when the simulation fails
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
  --top-module trace_tb -f vlog.f -o trace_sim \
  && ./obj_dir/trace_sim \
  || exit 1
